// File: mmu_config.svh
/*
 * Sv32 MMU widths and TLB sizes
 */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// --------------------------------------------------
// address format
// --------------------------------------------------
// virtual and physical address widths
`define MMU_VLEN 32
`define MMU_PLEN 34
// page numbers
`define MMU_PPNW 22
`define MMU_VPNW 20
// one level of the two-level vpn
`define MMU_VPN_LVLW 10
// 4 KiB page offset
`define MMU_PG_OFFS 12

// --------------------------------------------------
// TLB sizing
// --------------------------------------------------
`define MMU_ASIDW 9
`define MMU_ITLB_ENTRIES 4
`define MMU_DTLB_ENTRIES 8

`endif

// File: mmu_pkg.sv
/*
 * MMU types: privilege level, exception causes, PTE flags
 * and the physical address composition shared by both paths
 */
`default_nettype none
`include "mmu_config.svh"

package mmu_pkg;

  // privilege levels, encoded as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // RISC-V mcause codes used by the MMU
  typedef enum logic [3:0] {
    LOAD_MISALIGNED  = 4'd4,
    STORE_MISALIGNED = 4'd6,
    INSTR_PAGE_FAULT = 4'd12,
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  // low byte of an Sv32 PTE, d at the top
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_flags_t;

  // 4 KiB page: ppn + offset
  // megapage: ppn[1] + vpn[0] + offset straight from the vaddr
  function automatic logic [`MMU_PLEN-1:0] compose_paddr(
    input logic [`MMU_PPNW-1:0] ppn,
    input logic [`MMU_VLEN-1:0] vaddr,
    input logic                 mega
  );
    if (mega) begin
      return {ppn[`MMU_PPNW-1:`MMU_VPN_LVLW], vaddr[`MMU_PG_OFFS+`MMU_VPN_LVLW-1:0]};
    end
    return {ppn, vaddr[`MMU_PG_OFFS-1:0]};
  endfunction

endpackage

`default_nettype wire

// File: tlb.sv
/*
 * fully associative TLB with ASID/global match and megapages,
 * refilled round-robin through an external update port
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_config.svh"

module tlb #(
  parameter int unsigned NR_ENTRIES = `MMU_ITLB_ENTRIES
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     update_i,
  input  logic [`MMU_VPNW-1:0]     upd_vpn_i,
  input  logic [`MMU_PPNW-1:0]     upd_ppn_i,
  input  logic [`MMU_ASIDW-1:0]    upd_asid_i,
  input  logic                     upd_mega_i,
  input  mmu_pkg::pte_flags_t      upd_flags_i,
  input  logic [`MMU_VLEN-1:0]     lu_vaddr_i,
  input  logic [`MMU_ASIDW-1:0]    lu_asid_i,
  output logic                     lu_hit_o,
  output logic [`MMU_PPNW-1:0]     lu_ppn_o,
  output logic                     lu_mega_o,
  output mmu_pkg::pte_flags_t      lu_flags_o
);
  import mmu_pkg::*;

  localparam int unsigned PTR_W = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1;

  // entry payload
  logic [`MMU_VPN_LVLW-1:0] tag_vpn1_q [NR_ENTRIES];
  logic [`MMU_VPN_LVLW-1:0] tag_vpn0_q [NR_ENTRIES];
  logic [`MMU_PPNW-1:0]     ppn_q      [NR_ENTRIES];
  logic [`MMU_ASIDW-1:0]    asid_q     [NR_ENTRIES];
  logic                     mega_q     [NR_ENTRIES];
  pte_flags_t               flags_q    [NR_ENTRIES];
  // control
  logic [NR_ENTRIES-1:0]    valid_q;
  logic [PTR_W-1:0]         rr_ptr_q;
  logic                     do_write;
  // lookup
  logic [`MMU_VPN_LVLW-1:0] lu_vpn1;
  logic [`MMU_VPN_LVLW-1:0] lu_vpn0;
  logic [NR_ENTRIES-1:0]    match;

  // flush beats a refill in the same cycle, the refill is dropped
  assign do_write = update_i && !flush_i;

  // --------------------------------------------------
  // refill and flush
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rr_ptr_q <= '0;
    end else if (flush_i) begin
      // pointer survives a flush
      valid_q <= '0;
    end else if (do_write) begin
      valid_q[rr_ptr_q] <= 1'b1;
      if (rr_ptr_q == PTR_W'(NR_ENTRIES - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      tag_vpn1_q[rr_ptr_q] <= upd_vpn_i[`MMU_VPNW-1:`MMU_VPN_LVLW];
      tag_vpn0_q[rr_ptr_q] <= upd_vpn_i[`MMU_VPN_LVLW-1:0];
      ppn_q[rr_ptr_q]      <= upd_ppn_i;
      asid_q[rr_ptr_q]     <= upd_asid_i;
      mega_q[rr_ptr_q]     <= upd_mega_i;
      flags_q[rr_ptr_q]    <= upd_flags_i;
    end
  end

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------
  assign lu_vpn1 = lu_vaddr_i[`MMU_VLEN-1:`MMU_VLEN-`MMU_VPN_LVLW];
  assign lu_vpn0 = lu_vaddr_i[`MMU_PG_OFFS+`MMU_VPN_LVLW-1:`MMU_PG_OFFS];

  // vpn0 ignored for megapages, asid ignored for global entries
  always_comb begin
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      match[i] = valid_q[i]
              && (tag_vpn1_q[i] == lu_vpn1)
              && (mega_q[i] || (tag_vpn0_q[i] == lu_vpn0))
              && (flags_q[i].g || (asid_q[i] == lu_asid_i));
    end
  end

  // walk down so the lowest matching index is the last one written
  always_comb begin
    lu_hit_o   = 1'b0;
    lu_ppn_o   = '0;
    lu_mega_o  = 1'b0;
    lu_flags_o = '0;
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        lu_hit_o   = 1'b1;
        lu_ppn_o   = ppn_q[i];
        lu_mega_o  = mega_q[i];
        lu_flags_o = flags_q[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: fetch_xlate.sv
/*
 * instruction fetch translation, combinational in the request cycle
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_config.svh"

module fetch_xlate (
  input  logic                  enable_translation_i,
  input  mmu_pkg::priv_lvl_e    priv_lvl_i,
  input  logic                  fetch_req_i,
  input  logic [`MMU_VLEN-1:0]  fetch_vaddr_i,
  input  logic                  itlb_hit_i,
  input  logic [`MMU_PPNW-1:0]  itlb_ppn_i,
  input  logic                  itlb_mega_i,
  input  mmu_pkg::pte_flags_t   itlb_flags_i,
  output logic                  fetch_valid_o,
  output logic [`MMU_PLEN-1:0]  fetch_paddr_o,
  output logic                  fetch_ex_valid_o,
  output mmu_pkg::exc_cause_e   fetch_ex_cause_o,
  output logic [`MMU_VLEN-1:0]  fetch_ex_tval_o,
  output logic                  itlb_miss_o
);
  import mmu_pkg::*;

  logic iaccess_err;
  logic xlate_hit;

  // U-mode on a supervisor page, or S-mode on a user page
  assign iaccess_err = ((priv_lvl_i == PRIV_U) && !itlb_flags_i.u)
                    || ((priv_lvl_i == PRIV_S) && itlb_flags_i.u);

  assign xlate_hit = fetch_req_i && enable_translation_i && itlb_hit_i;

  always_comb begin
    // bare mode, address passes through
    fetch_valid_o    = fetch_req_i;
    fetch_paddr_o    = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, fetch_vaddr_i};
    fetch_ex_valid_o = 1'b0;
    // only fault a fetch can raise here
    fetch_ex_cause_o = INSTR_PAGE_FAULT;
    fetch_ex_tval_o  = '0;
    if (enable_translation_i) begin
      // held back on a miss until the TLB is refilled
      fetch_valid_o = xlate_hit;
      fetch_paddr_o = compose_paddr(itlb_ppn_i, fetch_vaddr_i, itlb_mega_i);
      if (xlate_hit && iaccess_err) begin
        fetch_ex_valid_o = 1'b1;
        fetch_ex_tval_o  = fetch_vaddr_i;
      end
    end
  end

  // perf counter strobe
  assign itlb_miss_o = fetch_req_i && enable_translation_i && !itlb_hit_i;

endmodule

`default_nettype wire

// File: lsu_xlate.sv
/*
 * load/store translation: DTLB lookup in cycle 0, registered,
 * physical address and exception out in cycle 1
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_config.svh"

module lsu_xlate (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_e    ld_st_priv_lvl_i,
  input  logic                  sum_i,
  input  logic                  lsu_req_i,
  input  logic [`MMU_VLEN-1:0]  lsu_vaddr_i,
  input  logic                  lsu_is_store_i,
  input  logic                  lsu_misaligned_i,
  input  logic                  dtlb_hit_i,
  input  logic [`MMU_PPNW-1:0]  dtlb_ppn_i,
  input  logic                  dtlb_mega_i,
  input  mmu_pkg::pte_flags_t   dtlb_flags_i,
  output logic                  lsu_dtlb_hit_o,
  output logic                  dtlb_miss_o,
  output logic                  lsu_valid_o,
  output logic [`MMU_PLEN-1:0]  lsu_paddr_o,
  output logic                  lsu_ex_valid_o,
  output mmu_pkg::exc_cause_e   lsu_ex_cause_o,
  output logic [`MMU_VLEN-1:0]  lsu_ex_tval_o
);
  import mmu_pkg::*;

  // request stage
  logic                  req_q;
  logic                  is_store_q;
  logic                  mis_q;
  logic                  hit_q;
  logic [`MMU_VLEN-1:0]  vaddr_q;
  logic [`MMU_PPNW-1:0]  ppn_q;
  logic                  mega_q;
  pte_flags_t            flags_q;
  // result stage
  logic                  daccess_err;
  logic                  page_fault;

  // --------------------------------------------------
  // cycle 0
  // --------------------------------------------------
  // always a hit in bare mode
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit_i : 1'b1;
  assign dtlb_miss_o    = lsu_req_i && en_ld_st_translation_i && !dtlb_hit_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q      <= 1'b0;
      is_store_q <= 1'b0;
      mis_q      <= 1'b0;
      hit_q      <= 1'b0;
    end else begin
      req_q      <= lsu_req_i;
      is_store_q <= lsu_is_store_i;
      // no stray misaligned fault without a request
      mis_q      <= lsu_misaligned_i && lsu_req_i;
      hit_q      <= dtlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q <= lsu_vaddr_i;
    ppn_q   <= dtlb_ppn_i;
    mega_q  <= dtlb_mega_i;
    flags_q <= dtlb_flags_i;
  end

  // --------------------------------------------------
  // cycle 1
  // --------------------------------------------------
  // S-mode on a user page needs SUM, U-mode needs a user page
  assign daccess_err = en_ld_st_translation_i
                    && (((ld_st_priv_lvl_i == PRIV_S) && !sum_i && flags_q.u)
                    ||  ((ld_st_priv_lvl_i == PRIV_U) && !flags_q.u));

  // stores also need W and D set
  assign page_fault = is_store_q ? (!flags_q.w || !flags_q.d || daccess_err) : daccess_err;

  assign lsu_valid_o = req_q && (!en_ld_st_translation_i || mis_q || hit_q);

  assign lsu_paddr_o = (en_ld_st_translation_i && !mis_q)
                     ? compose_paddr(ppn_q, vaddr_q, mega_q)
                     : {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};

  // misaligned first, then page fault
  always_comb begin
    lsu_ex_valid_o = 1'b0;
    lsu_ex_cause_o = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    lsu_ex_tval_o  = '0;
    if (mis_q) begin
      lsu_ex_valid_o = 1'b1;
      lsu_ex_cause_o = is_store_q ? STORE_MISALIGNED : LOAD_MISALIGNED;
      lsu_ex_tval_o  = vaddr_q;
    end else if (req_q && en_ld_st_translation_i && hit_q && page_fault) begin
      lsu_ex_valid_o = 1'b1;
      lsu_ex_tval_o  = vaddr_q;
    end
  end

endmodule

`default_nettype wire

// File: mmu_top.sv
/*
 * Sv32 MMU top: ITLB + fetch path, DTLB + load/store path
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_config.svh"

module mmu_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  enable_translation_i,
  input  logic                  en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_e    priv_lvl_i,
  input  mmu_pkg::priv_lvl_e    ld_st_priv_lvl_i,
  input  logic                  sum_i,
  input  logic [`MMU_ASIDW-1:0] asid_i,
  // refill and flush
  input  logic                  tlb_flush_i,
  input  logic                  itlb_update_i,
  input  logic                  dtlb_update_i,
  input  logic [`MMU_VPNW-1:0]  upd_vpn_i,
  input  logic [`MMU_PPNW-1:0]  upd_ppn_i,
  input  logic [`MMU_ASIDW-1:0] upd_asid_i,
  input  logic                  upd_mega_i,
  input  mmu_pkg::pte_flags_t   upd_flags_i,
  // instruction fetch
  input  logic                  fetch_req_i,
  input  logic [`MMU_VLEN-1:0]  fetch_vaddr_i,
  output logic                  fetch_valid_o,
  output logic [`MMU_PLEN-1:0]  fetch_paddr_o,
  output logic                  fetch_ex_valid_o,
  output mmu_pkg::exc_cause_e   fetch_ex_cause_o,
  output logic [`MMU_VLEN-1:0]  fetch_ex_tval_o,
  output logic                  itlb_miss_o,
  // load/store
  input  logic                  lsu_req_i,
  input  logic [`MMU_VLEN-1:0]  lsu_vaddr_i,
  input  logic                  lsu_is_store_i,
  input  logic                  lsu_misaligned_i,
  output logic                  lsu_dtlb_hit_o,
  output logic                  dtlb_miss_o,
  output logic                  lsu_valid_o,
  output logic [`MMU_PLEN-1:0]  lsu_paddr_o,
  output logic                  lsu_ex_valid_o,
  output mmu_pkg::exc_cause_e   lsu_ex_cause_o,
  output logic [`MMU_VLEN-1:0]  lsu_ex_tval_o
);
  import mmu_pkg::*;

  // lookup results
  logic                 itlb_hit;
  logic [`MMU_PPNW-1:0] itlb_ppn;
  logic                 itlb_mega;
  pte_flags_t           itlb_flags;
  logic                 dtlb_hit;
  logic [`MMU_PPNW-1:0] dtlb_ppn;
  logic                 dtlb_mega;
  pte_flags_t           dtlb_flags;

  // refill fields, clock and reset by name
  tlb #(.NR_ENTRIES(`MMU_ITLB_ENTRIES)) i_itlb (
    .flush_i    (tlb_flush_i),
    .update_i   (itlb_update_i),
    .lu_vaddr_i (fetch_vaddr_i),
    .lu_asid_i  (asid_i),
    .lu_hit_o   (itlb_hit),
    .lu_ppn_o   (itlb_ppn),
    .lu_mega_o  (itlb_mega),
    .lu_flags_o (itlb_flags),
    .*
  );

  tlb #(.NR_ENTRIES(`MMU_DTLB_ENTRIES)) i_dtlb (
    .flush_i    (tlb_flush_i),
    .update_i   (dtlb_update_i),
    .lu_vaddr_i (lsu_vaddr_i),
    .lu_asid_i  (asid_i),
    .lu_hit_o   (dtlb_hit),
    .lu_ppn_o   (dtlb_ppn),
    .lu_mega_o  (dtlb_mega),
    .lu_flags_o (dtlb_flags),
    .*
  );

  fetch_xlate i_fetch_xlate (
    .itlb_hit_i   (itlb_hit),
    .itlb_ppn_i   (itlb_ppn),
    .itlb_mega_i  (itlb_mega),
    .itlb_flags_i (itlb_flags),
    .*
  );

  lsu_xlate i_lsu_xlate (
    .dtlb_hit_i   (dtlb_hit),
    .dtlb_ppn_i   (dtlb_ppn),
    .dtlb_mega_i  (dtlb_mega),
    .dtlb_flags_i (dtlb_flags),
    .*
  );

endmodule

`default_nettype wire

// File: mmu_checker.sv
/*
 * MMU checker: TLB model beside the DUT that predicts every
 * output and compares it on the falling clock edge
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_config.svh"

module mmu_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  enable_translation_i,
  input  logic                  en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_e    priv_lvl_i,
  input  mmu_pkg::priv_lvl_e    ld_st_priv_lvl_i,
  input  logic                  sum_i,
  input  logic [`MMU_ASIDW-1:0] asid_i,
  input  logic                  tlb_flush_i,
  input  logic                  itlb_update_i,
  input  logic                  dtlb_update_i,
  input  logic [`MMU_VPNW-1:0]  upd_vpn_i,
  input  logic [`MMU_PPNW-1:0]  upd_ppn_i,
  input  logic [`MMU_ASIDW-1:0] upd_asid_i,
  input  logic                  upd_mega_i,
  input  mmu_pkg::pte_flags_t   upd_flags_i,
  input  logic                  fetch_req_i,
  input  logic [`MMU_VLEN-1:0]  fetch_vaddr_i,
  input  logic                  fetch_valid_o,
  input  logic [`MMU_PLEN-1:0]  fetch_paddr_o,
  input  logic                  fetch_ex_valid_o,
  input  mmu_pkg::exc_cause_e   fetch_ex_cause_o,
  input  logic [`MMU_VLEN-1:0]  fetch_ex_tval_o,
  input  logic                  itlb_miss_o,
  input  logic                  lsu_req_i,
  input  logic [`MMU_VLEN-1:0]  lsu_vaddr_i,
  input  logic                  lsu_is_store_i,
  input  logic                  lsu_misaligned_i,
  input  logic                  lsu_dtlb_hit_o,
  input  logic                  dtlb_miss_o,
  input  logic                  lsu_valid_o,
  input  logic [`MMU_PLEN-1:0]  lsu_paddr_o,
  input  logic                  lsu_ex_valid_o,
  input  mmu_pkg::exc_cause_e   lsu_ex_cause_o,
  input  logic [`MMU_VLEN-1:0]  lsu_ex_tval_o,
  output int                    err_cnt_o,
  output int                    chk_cnt_o
);
  import mmu_pkg::*;

  // model of both TLBs, index 0 is the ITLB and 1 the DTLB
  logic [`MMU_VPNW-1:0]  m_vpn   [2][`MMU_DTLB_ENTRIES];
  logic [`MMU_PPNW-1:0]  m_ppn   [2][`MMU_DTLB_ENTRIES];
  logic [`MMU_ASIDW-1:0] m_asid  [2][`MMU_DTLB_ENTRIES];
  logic                  m_mega  [2][`MMU_DTLB_ENTRIES];
  pte_flags_t            m_flags [2][`MMU_DTLB_ENTRIES];
  logic                  m_valid [2][`MMU_DTLB_ENTRIES];
  int                    m_ptr   [2];
  // load/store result expected in the next cycle
  logic                  p_valid;
  logic                  p_ex;
  exc_cause_e            p_cause;
  logic [`MMU_PLEN-1:0]  p_paddr;
  logic [`MMU_VLEN-1:0]  p_tval;
  int                    err_cnt = 0;
  int                    chk_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  // --------------------------------------------------
  // model helpers
  // --------------------------------------------------
  function automatic int tlb_size(input int t);
    return (t == 0) ? `MMU_ITLB_ENTRIES : `MMU_DTLB_ENTRIES;
  endfunction

  // lowest matching index, -1 on a miss
  function automatic int find_entry(input int t, input logic [`MMU_VLEN-1:0] va,
                                    input logic [`MMU_ASIDW-1:0] asid);
    for (int i = 0; i < tlb_size(t); i++) begin
      if (m_valid[t][i] && (m_vpn[t][i][19:10] == va[31:22])
          && (m_mega[t][i] || (m_vpn[t][i][9:0] == va[21:12]))
          && (m_flags[t][i].g || (m_asid[t][i] == asid))) begin
        return i;
      end
    end
    return -1;
  endfunction

  // 4 KiB page keeps the 12 bit offset, megapage keeps 22 bits of vaddr
  function automatic logic [`MMU_PLEN-1:0] xlate_addr(input int t, input int i,
                                                      input logic [`MMU_VLEN-1:0] va);
    if (m_mega[t][i]) begin
      return {m_ppn[t][i][21:10], va[21:0]};
    end
    return {m_ppn[t][i], va[11:0]};
  endfunction

  function automatic logic [`MMU_PLEN-1:0] zext(input logic [`MMU_VLEN-1:0] va);
    return {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, va};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
    end
  endtask

  task automatic clear_valid();
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < `MMU_DTLB_ENTRIES; i++) begin
        m_valid[t][i] = 1'b0;
      end
    end
  endtask

  // round-robin slot, pointer wraps at the TLB size
  task automatic write_entry(input int t);
    m_vpn[t][m_ptr[t]]   = upd_vpn_i;
    m_ppn[t][m_ptr[t]]   = upd_ppn_i;
    m_asid[t][m_ptr[t]]  = upd_asid_i;
    m_mega[t][m_ptr[t]]  = upd_mega_i;
    m_flags[t][m_ptr[t]] = upd_flags_i;
    m_valid[t][m_ptr[t]] = 1'b1;
    m_ptr[t] = (m_ptr[t] + 1) % tlb_size(t);
  endtask

  // --------------------------------------------------
  // fetch path, same cycle
  // --------------------------------------------------
  task automatic check_fetch();
    int                   idx;
    logic                 e_valid;
    logic                 e_ex;
    logic [`MMU_PLEN-1:0] e_paddr;
    pte_flags_t           fl;
    idx     = find_entry(0, fetch_vaddr_i, asid_i);
    e_valid = fetch_req_i;
    e_ex    = 1'b0;
    e_paddr = zext(fetch_vaddr_i);
    if (enable_translation_i) begin
      e_valid = fetch_req_i && (idx >= 0);
      if (idx >= 0) begin
        fl      = m_flags[0][idx];
        e_paddr = xlate_addr(0, idx, fetch_vaddr_i);
        // user meets supervisor page or supervisor meets user page
        e_ex    = e_valid && (((priv_lvl_i == PRIV_U) && !fl.u)
                  || ((priv_lvl_i == PRIV_S) && fl.u));
      end
    end
    check_value("fetch_valid_o", 64'(fetch_valid_o), 64'(e_valid));
    check_value("itlb_miss_o", 64'(itlb_miss_o),
                64'(fetch_req_i && enable_translation_i && (idx < 0)));
    check_value("fetch_ex_valid_o", 64'(fetch_ex_valid_o), 64'(e_ex));
    if (e_valid) begin
      check_value("fetch_paddr_o", 64'(fetch_paddr_o), 64'(e_paddr));
    end
    if (e_ex) begin
      check_value("fetch_ex_cause_o", 64'(fetch_ex_cause_o), 64'(INSTR_PAGE_FAULT));
      check_value("fetch_ex_tval_o", 64'(fetch_ex_tval_o), 64'(fetch_vaddr_i));
    end
  endtask

  // --------------------------------------------------
  // load/store path, result one cycle later
  // --------------------------------------------------
  task automatic check_lsu();
    int         idx;
    logic       fault;
    pte_flags_t fl;
    // result of last cycle's request
    check_value("lsu_valid_o", 64'(lsu_valid_o), 64'(p_valid));
    check_value("lsu_ex_valid_o", 64'(lsu_ex_valid_o), 64'(p_ex));
    if (p_valid) begin
      check_value("lsu_paddr_o", 64'(lsu_paddr_o), 64'(p_paddr));
    end
    if (p_ex) begin
      check_value("lsu_ex_cause_o", 64'(lsu_ex_cause_o), 64'(p_cause));
      check_value("lsu_ex_tval_o", 64'(lsu_ex_tval_o), 64'(p_tval));
    end
    // lookup strobes of this cycle
    idx = find_entry(1, lsu_vaddr_i, asid_i);
    check_value("lsu_dtlb_hit_o", 64'(lsu_dtlb_hit_o),
                64'(!en_ld_st_translation_i || (idx >= 0)));
    check_value("dtlb_miss_o", 64'(dtlb_miss_o),
                64'(lsu_req_i && en_ld_st_translation_i && (idx < 0)));
    p_valid = 1'b0;
    p_ex    = 1'b0;
    p_paddr = zext(lsu_vaddr_i);
    p_tval  = lsu_vaddr_i;
    p_cause = lsu_is_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    if (lsu_req_i && lsu_misaligned_i) begin
      // misaligned wins over any lookup result
      p_valid = 1'b1;
      p_ex    = 1'b1;
      p_cause = lsu_is_store_i ? STORE_MISALIGNED : LOAD_MISALIGNED;
    end else if (lsu_req_i && !en_ld_st_translation_i) begin
      p_valid = 1'b1;
    end else if (lsu_req_i && (idx >= 0)) begin
      fl    = m_flags[1][idx];
      fault = ((ld_st_priv_lvl_i == PRIV_S) && !sum_i && fl.u)
              || ((ld_st_priv_lvl_i == PRIV_U) && !fl.u);
      if (lsu_is_store_i) begin
        fault = fault || !fl.w || !fl.d;
      end
      p_valid = 1'b1;
      p_ex    = fault;
      p_paddr = xlate_addr(1, idx, lsu_vaddr_i);
    end
  endtask

  // inputs settle 2 ns after the rising edge, so compare mid-cycle
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      clear_valid();
      m_ptr[0] = 0;
      m_ptr[1] = 0;
      p_valid  = 1'b0;
      p_ex     = 1'b0;
    end else begin
      check_fetch();
      check_lsu();
      // flush beats a refill in the same cycle
      if (tlb_flush_i) begin
        clear_valid();
      end else begin
        if (itlb_update_i) begin
          write_entry(0);
        end
        if (dtlb_update_i) begin
          write_entry(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_mmu.sv
/*
 * MMU testbench: clock, reset, random refill, fetch and
 * load/store stimulus with a cycle limit
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_config.svh"

module tb_mmu;
  import mmu_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int REFILL_CYCLES  = `MMU_DTLB_ENTRIES;
  localparam int MIXED_CYCLES   = 2000;
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + REFILL_CYCLES + MIXED_CYCLES + 4);

  logic                  clk_i;
  logic                  rst_ni;
  logic                  enable_translation_i;
  logic                  en_ld_st_translation_i;
  priv_lvl_e             priv_lvl_i;
  priv_lvl_e             ld_st_priv_lvl_i;
  logic                  sum_i;
  logic [`MMU_ASIDW-1:0] asid_i;
  logic                  tlb_flush_i;
  logic                  itlb_update_i;
  logic                  dtlb_update_i;
  logic [`MMU_VPNW-1:0]  upd_vpn_i;
  logic [`MMU_PPNW-1:0]  upd_ppn_i;
  logic [`MMU_ASIDW-1:0] upd_asid_i;
  logic                  upd_mega_i;
  pte_flags_t            upd_flags_i;
  logic                  fetch_req_i;
  logic [`MMU_VLEN-1:0]  fetch_vaddr_i;
  logic                  fetch_valid_o;
  logic [`MMU_PLEN-1:0]  fetch_paddr_o;
  logic                  fetch_ex_valid_o;
  exc_cause_e            fetch_ex_cause_o;
  logic [`MMU_VLEN-1:0]  fetch_ex_tval_o;
  logic                  itlb_miss_o;
  logic                  lsu_req_i;
  logic [`MMU_VLEN-1:0]  lsu_vaddr_i;
  logic                  lsu_is_store_i;
  logic                  lsu_misaligned_i;
  logic                  lsu_dtlb_hit_o;
  logic                  dtlb_miss_o;
  logic                  lsu_valid_o;
  logic [`MMU_PLEN-1:0]  lsu_paddr_o;
  logic                  lsu_ex_valid_o;
  exc_cause_e            lsu_ex_cause_o;
  logic [`MMU_VLEN-1:0]  lsu_ex_tval_o;
  int                    err_cnt_o;
  int                    chk_cnt_o;
  integer                seed = 32'h136164a2;
  int                    cycle_cnt = 0;

  mmu_top dut0 (.*);

  mmu_checker chk0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // random helpers
  // --------------------------------------------------
  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic priv_lvl_e pick_priv();
    case (rnd(3))
      0: return PRIV_U;
      1: return PRIV_S;
      default: return PRIV_M;
    endcase
  endfunction

  // two vpn[1] x three vpn[0], small pool so hits and duplicates are common
  function automatic logic [`MMU_VPNW-1:0] pick_vpn();
    return {10'(rnd(2) + 32'h101), 10'(rnd(3) + 32'h5)};
  endfunction

  function automatic logic [`MMU_VLEN-1:0] pick_vaddr();
    return {pick_vpn(), 12'(rnd(4096))};
  endfunction

  task automatic drive_idle();
    enable_translation_i   = 1'b0;
    en_ld_st_translation_i = 1'b0;
    priv_lvl_i             = PRIV_M;
    ld_st_priv_lvl_i       = PRIV_M;
    sum_i                  = 1'b0;
    asid_i                 = '0;
    tlb_flush_i            = 1'b0;
    itlb_update_i          = 1'b0;
    dtlb_update_i          = 1'b0;
    upd_vpn_i              = '0;
    upd_ppn_i              = '0;
    upd_asid_i             = '0;
    upd_mega_i             = 1'b0;
    upd_flags_i            = '0;
    fetch_req_i            = 1'b0;
    fetch_vaddr_i          = '0;
    lsu_req_i              = 1'b0;
    lsu_vaddr_i            = '0;
    lsu_is_store_i         = 1'b0;
    lsu_misaligned_i       = 1'b0;
  endtask

  task automatic drive_refill_fields();
    upd_vpn_i   = pick_vpn();
    upd_ppn_i   = 22'(rnd(32'h40_0000));
    upd_asid_i  = 9'(rnd(2) + 1);
    upd_mega_i  = (rnd(4) == 0);
    // a and v always set
    upd_flags_i = pte_flags_t'(8'(rnd(256)) | 8'h41);
  endtask

  task automatic drive_mixed_cycle();
    tlb_flush_i          = (rnd(64) == 0);
    itlb_update_i        = (rnd(10) == 0);
    dtlb_update_i        = (rnd(8) == 0);
    drive_refill_fields();
    asid_i               = 9'(rnd(2) + 1);
    enable_translation_i = (rnd(4) != 0);
    priv_lvl_i           = pick_priv();
    fetch_req_i          = (rnd(2) == 0);
    fetch_vaddr_i        = pick_vaddr();
    // load/store mode changes only with no result pending
    if (!lsu_req_i) begin
      en_ld_st_translation_i = (rnd(4) != 0);
      ld_st_priv_lvl_i       = pick_priv();
      sum_i                  = (rnd(2) == 0);
    end
    lsu_req_i            = (rnd(3) != 0);
    lsu_vaddr_i          = pick_vaddr();
    lsu_is_store_i       = (rnd(2) == 0);
    lsu_misaligned_i     = (rnd(8) == 0);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    drive_idle();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // fill every slot of both TLBs
    for (int i = 0; i < REFILL_CYCLES; i++) begin
      drive_refill_fields();
      itlb_update_i = (i < `MMU_ITLB_ENTRIES);
      dtlb_update_i = 1'b1;
      @(posedge clk_i);
      #2;
    end
    for (int i = 0; i < MIXED_CYCLES; i++) begin
      drive_mixed_cycle();
      @(posedge clk_i);
      #2;
    end
    // drain, modes stay put for the last result
    fetch_req_i   = 1'b0;
    lsu_req_i     = 1'b0;
    tlb_flush_i   = 1'b0;
    itlb_update_i = 1'b0;
    dtlb_update_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    $display("checks: %0d, errors: %0d", chk_cnt_o, err_cnt_o);
    if ((err_cnt_o == 0) && (chk_cnt_o > 0)) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d", chk_cnt_o, err_cnt_o);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
mmu_pkg.sv
tlb.sv
fetch_xlate.sv
lsu_xlate.sv
mmu_top.sv
mmu_checker.sv
tb_mmu.sv

// File: run.sh
#!/usr/bin/env bash
# build the MMU testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mmu -f sim.f &&
  ./obj_dir/Vtb_mmu | tee /dev/stderr | grep -qx "Done: no errors" &&
  echo "PASS" || { echo "FAIL"; exit 1; }
